/* rtl/nlb_cfg.svh */
`ifndef NLB_CFG_SVH
`define NLB_CFG_SVH

// ---------------------------------------------------------------------------
// Datapath widths
// ---------------------------------------------------------------------------
// One cache line, shrunk to a single 64-bit word
`define NLB_LINE_W       64
// Line address, not byte address
`define NLB_ADDR_W       20
`define NLB_TAG_W        16
`define NLB_MMIO_ADDR_W  16

// ---------------------------------------------------------------------------
// Flow control and buffering
// ---------------------------------------------------------------------------
// Credits held by the requestor out of reset
`define NLB_MEM_CREDITS  4
// Loopback write FIFO entries, also caps reads in flight in LPBK1
`define NLB_LPBK_DEPTH   4

// Upper half of every WRITE mode line, lower half is the line index
`define NLB_WR_PATTERN   32'h4E4C_4257

// ---------------------------------------------------------------------------
// MMIO register byte offsets
// ---------------------------------------------------------------------------
`define NLB_CSR_SCRATCH     16'h0000
`define NLB_CSR_SRC         16'h0008
`define NLB_CSR_DST         16'h0010
`define NLB_CSR_NUM_LINES   16'h0018
`define NLB_CSR_CTL         16'h0020
`define NLB_CSR_CFG         16'h0028
`define NLB_CSR_STATUS      16'h0030
`define NLB_CSR_NUM_READS   16'h0038
`define NLB_CSR_NUM_WRITES  16'h0040

`endif

/* rtl/nlb_csr_pkg.sv */
`include "nlb_cfg.svh"

// Host side types for the MMIO window, test setup and test status
package nlb_csr_pkg;

   // ------------------------------------------------------------------------
   // MMIO request and response
   // ------------------------------------------------------------------------
   // Write and read enables are single cycle strobes
   typedef struct packed {
      logic                        wr_en;
      logic                        rd_en;
      logic [`NLB_MMIO_ADDR_W-1:0] addr;
      logic [63:0]                 data;
   } mmio_req_t;

   // Valid one cycle after rd_en
   typedef struct packed {
      logic        valid;
      logic [63:0] data;
   } mmio_rsp_t;

   // ------------------------------------------------------------------------
   // Test setup
   // ------------------------------------------------------------------------
   // Mode lives in CFG[3:2]
   typedef enum logic [1:0] {
      LPBK1 = 2'd0,
      READ  = 2'd1,
      WRITE = 2'd2
   } test_mode_e;

   // Engine view of the register file
   typedef struct packed {
      logic [`NLB_ADDR_W-1:0] src;
      logic [`NLB_ADDR_W-1:0] dst;
      logic [15:0]            num_lines;
      test_mode_e             mode;
      // CTL[1] starts the test
      logic                   run;
      // CTL[0] is the active low test reset
      logic                   test_rst_n;
   } test_cfg_t;

   // ------------------------------------------------------------------------
   // Test status
   // ------------------------------------------------------------------------
   // Done maps to STATUS[0] and busy to STATUS[1]
   typedef struct packed {
      logic busy;
      logic done;
   } test_status_t;

endpackage

/* rtl/nlb_mem_pkg.sv */
`include "nlb_cfg.svh"

// Memory channel types, between engine, requestor and memory
package nlb_mem_pkg;

   typedef logic [`NLB_LINE_W-1:0] line_t;

   typedef enum logic {
      OP_RD = 1'b0,
      OP_WR = 1'b1
   } mem_op_e;

   // Request toward memory, one per valid cycle, one credit each
   typedef struct packed {
      logic                   valid;
      mem_op_e                op;
      logic [`NLB_ADDR_W-1:0] addr;
      logic [`NLB_TAG_W-1:0]  tag;
      line_t                  data;
   } mem_req_t;

   // Response, never back-pressured
   // Data only meaningful on reads
   typedef struct packed {
      logic                  valid;
      mem_op_e               op;
      logic [`NLB_TAG_W-1:0] tag;
      line_t                 data;
   } mem_rsp_t;

   // Engine read request, held until rd_sent
   typedef struct packed {
      logic                   valid;
      logic [`NLB_ADDR_W-1:0] addr;
      logic [`NLB_TAG_W-1:0]  tag;
   } eng_rd_t;

   // Engine write request, held until wr_sent
   typedef struct packed {
      logic                   valid;
      logic [`NLB_ADDR_W-1:0] addr;
      line_t                  data;
   } eng_wr_t;

endpackage

/* rtl/nlb_csr.sv */
`timescale 1ns/1ns
`include "nlb_cfg.svh"

module nlb_csr (
   input  logic                       Clk_100,
   input  logic                       reset,
   input  nlb_csr_pkg::mmio_req_t     mmio_req,
   output nlb_csr_pkg::mmio_rsp_t     mmio_rsp,
   input  nlb_csr_pkg::test_status_t  status,
   input  logic [31:0]                num_reads,
   input  logic [31:0]                num_writes,
   output nlb_csr_pkg::test_cfg_t     cfg
);

   logic [63:0] scratch_q;
   logic [63:0] src_q;
   logic [63:0] dst_q;
   logic [31:0] num_lines_q;
   logic [31:0] cfg_q;
   logic [1:0]  ctl_q;
   logic [63:0] rd_data;

   // ------------------------------------------------------------------------
   // Register writes
   // ------------------------------------------------------------------------
   always_ff @(posedge Clk_100) begin
      if (reset) begin
         scratch_q   <= '0;
         src_q       <= '0;
         dst_q       <= '0;
         num_lines_q <= '0;
         cfg_q       <= '0;
         ctl_q       <= '0;
      end else begin
         // Scratchpad and control are always writable
         if (mmio_req.wr_en && mmio_req.addr == `NLB_CSR_SCRATCH)
            scratch_q <= mmio_req.data;
         if (mmio_req.wr_en && mmio_req.addr == `NLB_CSR_CTL)
            ctl_q <= mmio_req.data[1:0];

         // Test reset low holds the setup at defaults
         if (!ctl_q[0]) begin
            src_q       <= '0;
            dst_q       <= '0;
            num_lines_q <= '0;
            cfg_q       <= '0;
         end else if (mmio_req.wr_en && !status.busy) begin
            // Setup locked while a test runs
            case (mmio_req.addr)
               `NLB_CSR_SRC:       src_q       <= mmio_req.data;
               `NLB_CSR_DST:       dst_q       <= mmio_req.data;
               `NLB_CSR_NUM_LINES: num_lines_q <= mmio_req.data[31:0];
               `NLB_CSR_CFG:       cfg_q       <= mmio_req.data[31:0];
               default: ;
            endcase
         end
      end
   end

   // ------------------------------------------------------------------------
   // Read decode, unmapped offsets read zero
   // ------------------------------------------------------------------------
   always_comb begin
      case (mmio_req.addr)
         `NLB_CSR_SCRATCH:    rd_data = scratch_q;
         `NLB_CSR_SRC:        rd_data = src_q;
         `NLB_CSR_DST:        rd_data = dst_q;
         `NLB_CSR_NUM_LINES:  rd_data = {32'd0, num_lines_q};
         `NLB_CSR_CTL:        rd_data = {62'd0, ctl_q};
         `NLB_CSR_CFG:        rd_data = {32'd0, cfg_q};
         `NLB_CSR_STATUS:     rd_data = {62'd0, status.busy, status.done};
         `NLB_CSR_NUM_READS:  rd_data = {32'd0, num_reads};
         `NLB_CSR_NUM_WRITES: rd_data = {32'd0, num_writes};
         default:             rd_data = '0;
      endcase
   end

   // One cycle read latency
   always_ff @(posedge Clk_100) begin
      if (reset) begin
         mmio_rsp <= '0;
      end else begin
         mmio_rsp.valid <= mmio_req.rd_en;
         mmio_rsp.data  <= rd_data;
      end
   end

   // Engine view, addresses truncated to line address width
   always_comb begin
      cfg.src        = src_q[`NLB_ADDR_W-1:0];
      cfg.dst        = dst_q[`NLB_ADDR_W-1:0];
      cfg.num_lines  = num_lines_q[15:0];
      cfg.mode       = nlb_csr_pkg::test_mode_e'(cfg_q[3:2]);
      cfg.run        = ctl_q[1];
      cfg.test_rst_n = ctl_q[0];
   end

endmodule

/* rtl/nlb_test_engine.sv */
`timescale 1ns/1ns
`include "nlb_cfg.svh"

module nlb_test_engine (
   input  logic                       Clk_100,
   input  logic                       reset,
   input  nlb_csr_pkg::test_cfg_t     cfg,
   output nlb_csr_pkg::test_status_t  status,
   output nlb_mem_pkg::eng_rd_t       rd_req,
   input  logic                       rd_sent,
   output nlb_mem_pkg::eng_wr_t       wr_req,
   input  logic                       wr_sent,
   input  nlb_mem_pkg::mem_rsp_t      mem_rsp
);

   // Extra pointer bit tells full from empty
   localparam int PTR_W  = $clog2(`NLB_LPBK_DEPTH) + 1;
   localparam int SLOT_W = $clog2(`NLB_LPBK_DEPTH + 1);

   typedef enum logic [1:0] {
      IDLE,
      RUN,
      DRAIN,
      DONE
   } state_e;

   state_e                 state;
   logic [15:0]            issue_cnt;
   logic [15:0]            cmpl_cnt;
   // Reads in flight plus FIFO entries
   logic [SLOT_W-1:0]      slots;
   logic [PTR_W-1:0]       wr_ptr;
   logic [PTR_W-1:0]       rd_ptr;
   logic [`NLB_ADDR_W-1:0] fifo_addr [`NLB_LPBK_DEPTH];
   nlb_mem_pkg::line_t     fifo_data [`NLB_LPBK_DEPTH];
   logic                   is_lpbk;
   logic                   is_read;
   logic                   is_write;
   logic                   active;
   logic                   all_issued;
   logic                   fifo_empty;
   logic                   fifo_push;
   logic                   fifo_pop;
   logic                   rsp_done;

   assign is_lpbk    = cfg.mode == nlb_csr_pkg::LPBK1;
   assign is_read    = cfg.mode == nlb_csr_pkg::READ;
   assign is_write   = cfg.mode == nlb_csr_pkg::WRITE;
   assign active     = state == RUN || state == DRAIN;
   assign all_issued = issue_cnt == cfg.num_lines;
   assign fifo_empty = wr_ptr == rd_ptr;

   // Read data comes back as a loopback write
   assign fifo_push = active && is_lpbk && mem_rsp.valid && mem_rsp.op == nlb_mem_pkg::OP_RD;
   assign fifo_pop  = is_lpbk && wr_sent;
   // READ completes on read responses, the others on write responses
   assign rsp_done  = active && mem_rsp.valid &&
                      mem_rsp.op == (is_read ? nlb_mem_pkg::OP_RD : nlb_mem_pkg::OP_WR);

   // ------------------------------------------------------------------------
   // Request generation
   // ------------------------------------------------------------------------
   always_comb begin
      // LPBK1 reads stop while every FIFO slot is spoken for
      rd_req.valid = state == RUN && !all_issued &&
                     (is_read || (is_lpbk && slots < SLOT_W'(`NLB_LPBK_DEPTH)));
      rd_req.addr  = cfg.src + `NLB_ADDR_W'(issue_cnt);
      rd_req.tag   = `NLB_TAG_W'(issue_cnt);

      if (is_lpbk) begin
         wr_req.valid = active && !fifo_empty;
         wr_req.addr  = fifo_addr[rd_ptr[PTR_W-2:0]];
         wr_req.data  = fifo_data[rd_ptr[PTR_W-2:0]];
      end else begin
         wr_req.valid = state == RUN && is_write && !all_issued;
         wr_req.addr  = cfg.dst + `NLB_ADDR_W'(issue_cnt);
         wr_req.data  = {`NLB_WR_PATTERN, 32'(issue_cnt)};
      end

      status.busy = active;
      status.done = state == DONE;
   end

   // ------------------------------------------------------------------------
   // FSM
   // ------------------------------------------------------------------------
   always_ff @(posedge Clk_100) begin
      if (reset) begin
         state <= IDLE;
      end else begin
         case (state)
            IDLE:    if (cfg.run && cfg.test_rst_n) state <= RUN;
            RUN:     if (all_issued) state <= DRAIN;
            DRAIN:   if (cmpl_cnt == cfg.num_lines) state <= DONE;
            default: ;
         endcase
         // Run or test reset cleared aborts from any state
         if (!cfg.run || !cfg.test_rst_n)
            state <= IDLE;
      end
   end

   // Counters and FIFO pointers restart whenever the engine is idle
   always_ff @(posedge Clk_100) begin
      if (reset || state == IDLE) begin
         issue_cnt <= '0;
         cmpl_cnt  <= '0;
         slots     <= '0;
         wr_ptr    <= '0;
         rd_ptr    <= '0;
      end else begin
         if (rd_sent || (is_write && wr_sent))
            issue_cnt <= issue_cnt + 16'd1;
         if (rsp_done)
            cmpl_cnt <= cmpl_cnt + 16'd1;
         if (fifo_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (fifo_pop)
            rd_ptr <= rd_ptr + 1'b1;
         slots <= slots + SLOT_W'(is_lpbk && rd_sent) - SLOT_W'(fifo_pop);
      end
   end

   // Loopback FIFO storage, tag is the line index
   always_ff @(posedge Clk_100) begin
      if (fifo_push) begin
         fifo_addr[wr_ptr[PTR_W-2:0]] <= cfg.dst + `NLB_ADDR_W'(mem_rsp.tag);
         fifo_data[wr_ptr[PTR_W-2:0]] <= mem_rsp.data;
      end
   end

endmodule

/* rtl/nlb_requestor.sv */
`timescale 1ns/1ns
`include "nlb_cfg.svh"

module nlb_requestor (
   input  logic                   Clk_100,
   input  logic                   reset,
   input  logic                   start,
   input  nlb_mem_pkg::eng_rd_t   rd_req,
   output logic                   rd_sent,
   input  nlb_mem_pkg::eng_wr_t   wr_req,
   output logic                   wr_sent,
   output nlb_mem_pkg::mem_req_t  mem_req,
   input  logic                   credit_ret,
   output logic [31:0]            num_reads,
   output logic [31:0]            num_writes
);

   localparam int CRED_W = $clog2(`NLB_MEM_CREDITS + 1);

   logic [CRED_W-1:0]     credits;
   logic [`NLB_TAG_W-1:0] wr_tag;
   logic                  has_credit;
   logic                  wr_go;
   logic                  rd_go;

   // ------------------------------------------------------------------------
   // Selection, write first
   // ------------------------------------------------------------------------
   assign has_credit = credits != '0;
   assign wr_go      = wr_req.valid && has_credit;
   assign rd_go      = rd_req.valid && has_credit && !wr_req.valid;

   // Sent strobes let the engine advance on the same edge
   assign wr_sent = wr_go;
   assign rd_sent = rd_go;

   // Request leaves in the cycle it is granted a credit
   always_comb begin
      mem_req.valid = wr_go || rd_go;
      mem_req.op    = wr_go ? nlb_mem_pkg::OP_WR : nlb_mem_pkg::OP_RD;
      mem_req.addr  = wr_go ? wr_req.addr : rd_req.addr;
      mem_req.tag   = wr_go ? wr_tag : rd_req.tag;
      mem_req.data  = wr_go ? wr_req.data : '0;
   end

   // ------------------------------------------------------------------------
   // Credits
   // ------------------------------------------------------------------------
   // One spent per request, one back per retired request
   always_ff @(posedge Clk_100) begin
      if (reset)
         credits <= CRED_W'(`NLB_MEM_CREDITS);
      else
         credits <= credits - CRED_W'(mem_req.valid) + CRED_W'(credit_ret);
   end

   // ------------------------------------------------------------------------
   // Statistics and write tags
   // ------------------------------------------------------------------------
   always_ff @(posedge Clk_100) begin
      if (reset) begin
         num_reads  <= '0;
         num_writes <= '0;
         wr_tag     <= '0;
      end else begin
         // Start clears, a request in the start cycle still counts
         num_reads  <= (start ? 32'd0 : num_reads) + 32'(rd_go);
         num_writes <= (start ? 32'd0 : num_writes) + 32'(wr_go);
         // Free running, write responses are only counted
         if (wr_go)
            wr_tag <= wr_tag + 1'b1;
      end
   end

endmodule

/* rtl/nlb_lpbk.sv */
`timescale 1ns/1ns

module nlb_lpbk (
   input  logic                   Clk_100,
   input  logic                   reset,
   input  nlb_csr_pkg::mmio_req_t mmio_req,
   output nlb_csr_pkg::mmio_rsp_t mmio_rsp,
   output nlb_mem_pkg::mem_req_t  mem_req,
   input  logic                   credit_ret,
   input  nlb_mem_pkg::mem_rsp_t  mem_rsp
);

   // Starts high so the blocks come up in reset
   logic                      reset_q = 1'b1;
   logic                      busy_q;
   logic                      start;
   nlb_csr_pkg::test_cfg_t    cfg;
   nlb_csr_pkg::test_status_t status;
   nlb_mem_pkg::eng_rd_t      rd_req;
   nlb_mem_pkg::eng_wr_t      wr_req;
   logic                      rd_sent;
   logic                      wr_sent;
   logic [31:0]               num_reads;
   logic [31:0]               num_writes;

   // One stage of reset delay in front of all blocks
   always_ff @(posedge Clk_100) begin
      reset_q <= reset;
   end

   // Busy rising edge restarts the request statistics
   always_ff @(posedge Clk_100) begin
      if (reset_q)
         busy_q <= 1'b0;
      else
         busy_q <= status.busy;
   end

   assign start = status.busy && !busy_q;

   // ------------------------------------------------------------------------
   // Register block steers the engine
   // ------------------------------------------------------------------------
   nlb_csr csr_i (
      .Clk_100    (Clk_100),
      .reset      (reset_q),
      .mmio_req   (mmio_req),
      .mmio_rsp   (mmio_rsp),
      .status     (status),
      .num_reads  (num_reads),
      .num_writes (num_writes),
      .cfg        (cfg)
   );

   nlb_test_engine engine_i (
      .Clk_100 (Clk_100),
      .reset   (reset_q),
      .cfg     (cfg),
      .status  (status),
      .rd_req  (rd_req),
      .rd_sent (rd_sent),
      .wr_req  (wr_req),
      .wr_sent (wr_sent),
      .mem_rsp (mem_rsp)
   );

   // Memory side, credit protected
   nlb_requestor requestor_i (
      .Clk_100    (Clk_100),
      .reset      (reset_q),
      .start      (start),
      .rd_req     (rd_req),
      .rd_sent    (rd_sent),
      .wr_req     (wr_req),
      .wr_sent    (wr_sent),
      .mem_req    (mem_req),
      .credit_ret (credit_ret),
      .num_reads  (num_reads),
      .num_writes (num_writes)
   );

endmodule

/* tb/nlb_lpbk_properties.sv */
`timescale 1ns/1ns
`include "nlb_cfg.svh"

module nlb_lpbk_properties (
   input logic                   Clk_100,
   input logic                   reset,
   input nlb_csr_pkg::mmio_req_t mmio_req,
   input nlb_csr_pkg::mmio_rsp_t mmio_rsp,
   input nlb_mem_pkg::mem_req_t  mem_req,
   input logic                   credit_ret
);

   // Requests sent and not yet retired
   logic [7:0] outstanding;
   // Reset seen on the previous edge, flops are known from then on
   logic       reset_d = 1'b0;

   always @(posedge Clk_100) begin
      reset_d <= reset;
      if (reset)
         outstanding <= '0;
      else
         outstanding <= outstanding + 8'(mem_req.valid) - 8'(credit_ret);
   end

   // ------------------------------------------------------------------------
   // MMIO read timing
   // ------------------------------------------------------------------------
   mmio_rsp_after_rd: assert property (@(posedge Clk_100) disable iff (reset)
      mmio_req.rd_en |=> mmio_rsp.valid)
      else $error("MMIO response missing one cycle after read enable");

   mmio_rsp_only_after_rd: assert property (@(posedge Clk_100) disable iff (reset)
      mmio_rsp.valid |-> $past(mmio_req.rd_en))
      else $error("MMIO response without a read enable one cycle before");

   // ------------------------------------------------------------------------
   // Memory channel
   // ------------------------------------------------------------------------
   credits_bound: assert property (@(posedge Clk_100) disable iff (reset)
      outstanding <= 8'(`NLB_MEM_CREDITS))
      else $error("More requests in flight than credits");

   no_req_in_reset: assert property (@(posedge Clk_100)
      reset && reset_d |-> !mem_req.valid)
      else $error("Memory request valid during reset");

   op_known: assert property (@(posedge Clk_100) disable iff (reset)
      mem_req.valid |-> !$isunknown(mem_req.op))
      else $error("Memory request opcode unknown while valid");

endmodule

bind nlb_lpbk nlb_lpbk_properties props_i (
   .Clk_100    (Clk_100),
   .reset      (reset),
   .mmio_req   (mmio_req),
   .mmio_rsp   (mmio_rsp),
   .mem_req    (mem_req),
   .credit_ret (credit_ret)
);

/* tb/tb_nlb_lpbk.sv */
`timescale 1ns/1ns
`include "nlb_cfg.svh"

module tb_nlb_lpbk;

   localparam int MEM_LINES = 1 << `NLB_ADDR_W;
   // Line counts of all runs times 10 cycles plus margin
   localparam int WD_CYCLES = (12 + 9 + 20 + 16 + 4) * 10 + 2000;

   // Request waiting in the memory model until its due cycle
   typedef struct packed {
      nlb_mem_pkg::mem_op_e   op;
      logic [`NLB_ADDR_W-1:0] addr;
      logic [`NLB_TAG_W-1:0]  tag;
      nlb_mem_pkg::line_t     data;
      int unsigned            due;
   } pend_t;

   logic                   Clk_100;
   logic                   reset = 1'b1;
   nlb_csr_pkg::mmio_req_t mmio_req = '0;
   nlb_csr_pkg::mmio_rsp_t mmio_rsp;
   nlb_mem_pkg::mem_req_t  mem_req;
   logic                   credit_ret = 1'b0;
   nlb_mem_pkg::mem_rsp_t  mem_rsp = '0;

   nlb_mem_pkg::line_t mem_lines [MEM_LINES];
   pend_t              pend_q [$];
   int unsigned        delay_tab [256];
   int unsigned        req_cnt = 0;
   int unsigned        wr_seen = 0;
   int unsigned        cyc = 0;
   int                 checks = 0;
   int                 value_errs = 0;
   int                 other_errs = 0;

   initial begin
      Clk_100 = 1'b0;
      forever #4 Clk_100 = ~Clk_100;
   end

   nlb_lpbk dut_i (
      .Clk_100    (Clk_100),
      .reset      (reset),
      .mmio_req   (mmio_req),
      .mmio_rsp   (mmio_rsp),
      .mem_req    (mem_req),
      .credit_ret (credit_ret),
      .mem_rsp    (mem_rsp)
   );

   // ------------------------------------------------------------------------
   // Memory model with one out of order retirement per cycle
   // ------------------------------------------------------------------------
   always @(posedge Clk_100) begin
      pend_t                 ent;
      nlb_mem_pkg::mem_rsp_t rsp;
      int                    hit;
      hit = -1;
      rsp = '0;
      cyc <= cyc + 1;
      if (reset) begin
         pend_q.delete();
      end else begin
         if (mem_req.valid) begin
            ent.op   = mem_req.op;
            ent.addr = mem_req.addr;
            ent.tag  = mem_req.tag;
            ent.data = mem_req.data;
            // Delay of 1 to 6 cycles from the seeded table
            ent.due  = cyc + delay_tab[req_cnt % 256];
            pend_q.push_back(ent);
            req_cnt++;
         end
         // Oldest request that is due goes first
         foreach (pend_q[i])
            if (hit < 0 && pend_q[i].due <= cyc)
               hit = i;
         if (hit >= 0) begin
            ent = pend_q[hit];
            pend_q.delete(hit);
            rsp.valid = 1'b1;
            rsp.op    = ent.op;
            rsp.tag   = ent.tag;
            if (ent.op == nlb_mem_pkg::OP_WR) begin
               mem_lines[ent.addr] = ent.data;
               wr_seen++;
            end else begin
               rsp.data = mem_lines[ent.addr];
            end
         end
      end
      mem_rsp    <= rsp;
      credit_ret <= (hit >= 0);
   end

   // Background contents unique per line address
   function automatic nlb_mem_pkg::line_t fill_word(input int unsigned a);
      return {a, ~a} ^ 64'hC3C3_0000_0000_3C3C;
   endfunction

   // ------------------------------------------------------------------------
   // MMIO access and compare tasks
   // ------------------------------------------------------------------------
   task automatic write_reg(input logic [15:0] addr, input logic [63:0] data);
      @(posedge Clk_100);
      mmio_req.wr_en <= 1'b1;
      mmio_req.addr  <= addr;
      mmio_req.data  <= data;
      @(posedge Clk_100);
      mmio_req <= '0;
   endtask

   task automatic read_reg(input logic [15:0] addr, output logic [63:0] data);
      int waited;
      waited = 0;
      @(posedge Clk_100);
      mmio_req.rd_en <= 1'b1;
      mmio_req.addr  <= addr;
      @(posedge Clk_100);
      mmio_req <= '0;
      @(posedge Clk_100);
      while (!mmio_rsp.valid && waited < 4) begin
         @(posedge Clk_100);
         waited++;
      end
      if (!mmio_rsp.valid) begin
         $display("No MMIO read response for offset %h at %0t", addr, $time);
         other_errs++;
      end
      data = mmio_rsp.data;
   endtask

   task automatic check_word(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
         value_errs++;
      end
   endtask

   task automatic check_line(input string name, input nlb_mem_pkg::line_t got,
                             input nlb_mem_pkg::line_t exp);
      checks++;
      if (got !== exp) begin
         $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
         value_errs++;
      end
   endtask

   task automatic expect_reg(input logic [15:0] addr, input string name,
                             input logic [63:0] exp);
      logic [63:0] got;
      read_reg(addr, got);
      check_word(name, got, exp);
   endtask

   // ------------------------------------------------------------------------
   // Run control
   // ------------------------------------------------------------------------
   task automatic program_test(input logic [63:0] src, input logic [63:0] dst,
                               input int lines, input nlb_csr_pkg::test_mode_e mode);
      write_reg(`NLB_CSR_SRC, src);
      write_reg(`NLB_CSR_DST, dst);
      write_reg(`NLB_CSR_NUM_LINES, 64'(lines));
      // Mode sits in CFG[3:2]
      write_reg(`NLB_CSR_CFG, {60'd0, mode, 2'b00});
      // Test reset stays high and run goes high
      write_reg(`NLB_CSR_CTL, 64'h3);
   endtask

   task automatic stop_run();
      write_reg(`NLB_CSR_CTL, 64'h1);
   endtask

   // Poll STATUS until done within a bound set by the line count
   task automatic wait_done(input int lines, input string name);
      logic [63:0] st;
      int unsigned t0;
      st = '0;
      t0 = cyc;
      while (!st[0] && cyc - t0 < lines * 10 + 100)
         read_reg(`NLB_CSR_STATUS, st);
      if (!st[0]) begin
         $display("%s: done did not set within %0d cycles", name, lines * 10 + 100);
         other_errs++;
      end
   endtask

   // ------------------------------------------------------------------------
   // Directed tests
   // ------------------------------------------------------------------------
   task automatic register_access();
      write_reg(`NLB_CSR_SCRATCH, 64'hA5A5_1234_5A5A_9876);
      expect_reg(`NLB_CSR_SCRATCH, "SCRATCH", 64'hA5A5_1234_5A5A_9876);
      expect_reg(16'h0048, "unmapped offset 0x48", 64'h0);
      write_reg(`NLB_CSR_SRC, 64'h0000_0000_000A_BCDE);
      write_reg(`NLB_CSR_DST, 64'h0000_0000_0001_2345);
      write_reg(`NLB_CSR_NUM_LINES, 64'h33);
      write_reg(`NLB_CSR_CFG, 64'h8);
      expect_reg(`NLB_CSR_SRC, "SRC", 64'h0000_0000_000A_BCDE);
      expect_reg(`NLB_CSR_DST, "DST", 64'h0000_0000_0001_2345);
      expect_reg(`NLB_CSR_NUM_LINES, "NUM_LINES", 64'h33);
      expect_reg(`NLB_CSR_CFG, "CFG", 64'h8);
   endtask

   task automatic write_pattern();
      program_test(64'h0, 64'h100, 12, nlb_csr_pkg::WRITE);
      wait_done(12, "WRITE mode");
      expect_reg(`NLB_CSR_NUM_WRITES, "NUM_WRITES", 64'd12);
      expect_reg(`NLB_CSR_NUM_READS, "NUM_READS", 64'd0);
      stop_run();
      // Upper half holds the pattern and lower half the line index
      for (int i = 0; i < 12; i++)
         check_line($sformatf("mem[0x%0h]", 'h100 + i), mem_lines['h100 + i],
                    {`NLB_WR_PATTERN, 32'(i)});
   endtask

   task automatic read_only();
      int unsigned seen;
      seen = wr_seen;
      program_test(64'h180, 64'h7F0, 9, nlb_csr_pkg::READ);
      wait_done(9, "READ mode");
      expect_reg(`NLB_CSR_NUM_READS, "NUM_READS", 64'd9);
      check_word("memory writes in READ mode", 64'(wr_seen - seen), 64'd0);
      stop_run();
   endtask

   task automatic loopback_copy();
      nlb_mem_pkg::line_t src_line [20];
      for (int i = 0; i < 20; i++) begin
         src_line[i] = {$urandom, $urandom};
         mem_lines['h200 + i] = src_line[i];
      end
      program_test(64'h200, 64'h300, 20, nlb_csr_pkg::LPBK1);
      wait_done(20, "LPBK1 mode");
      expect_reg(`NLB_CSR_NUM_READS, "NUM_READS", 64'd20);
      expect_reg(`NLB_CSR_NUM_WRITES, "NUM_WRITES", 64'd20);
      stop_run();
      for (int i = 0; i < 20; i++)
         check_line($sformatf("mem[0x%0h]", 'h300 + i), mem_lines['h300 + i], src_line[i]);
   endtask

   task automatic write_lock();
      logic [63:0] st;
      int          polls;
      st    = '0;
      polls = 0;
      program_test(64'h0, 64'h400, 16, nlb_csr_pkg::WRITE);
      // Wait for busy so the next write lands mid run
      while (!st[1] && polls < 20) begin
         read_reg(`NLB_CSR_STATUS, st);
         polls++;
      end
      if (!st[1]) begin
         $display("Write lock: busy never seen during the run");
         other_errs++;
      end
      write_reg(`NLB_CSR_NUM_LINES, 64'd5);
      wait_done(16, "write lock run");
      expect_reg(`NLB_CSR_NUM_LINES, "NUM_LINES after locked write", 64'd16);
      stop_run();
   endtask

   task automatic config_reset();
      program_test(64'h60, 64'h500, 4, nlb_csr_pkg::WRITE);
      wait_done(4, "test reset run");
      write_reg(`NLB_CSR_SCRATCH, 64'h0123_4567_89AB_CDEF);
      // Test reset low while run stays high
      write_reg(`NLB_CSR_CTL, 64'h2);
      expect_reg(`NLB_CSR_SRC, "SRC after test reset", 64'h0);
      expect_reg(`NLB_CSR_DST, "DST after test reset", 64'h0);
      expect_reg(`NLB_CSR_NUM_LINES, "NUM_LINES after test reset", 64'h0);
      expect_reg(`NLB_CSR_CFG, "CFG after test reset", 64'h0);
      expect_reg(`NLB_CSR_STATUS, "STATUS after test reset", 64'h0);
      expect_reg(`NLB_CSR_SCRATCH, "SCRATCH after test reset", 64'h0123_4567_89AB_CDEF);
      write_reg(`NLB_CSR_CTL, 64'h1);
   endtask

   // ------------------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------------------
   initial begin
      void'($urandom(56664));
      foreach (delay_tab[i])
         delay_tab[i] = $urandom_range(6, 1);
      for (int a = 0; a < MEM_LINES; a++)
         mem_lines[a] = fill_word(a);
      repeat (3) @(posedge Clk_100);
      reset <= 1'b0;
      // Delayed reset inside the DUT clears one cycle later
      repeat (2) @(posedge Clk_100);
      write_reg(`NLB_CSR_CTL, 64'h1);
      register_access();
      write_pattern();
      read_only();
      loopback_copy();
      write_lock();
      config_reset();
      $display("Result: %0d checks, %0d value errors, %0d other errors",
               checks, value_errs, other_errs);
      if (value_errs + other_errs == 0)
         $display("TEST OK");
      else
         $display("TEST FAILED");
      $finish;
   end

   // Watchdog
   initial begin
      repeat (WD_CYCLES) @(posedge Clk_100);
      $display("Timeout: run did not finish within %0d cycles", WD_CYCLES);
      $display("TEST FAILED");
      $finish;
   end

endmodule

/* list.f */
+incdir+rtl
rtl/nlb_csr_pkg.sv
rtl/nlb_mem_pkg.sv
rtl/nlb_csr.sv
rtl/nlb_test_engine.sv
rtl/nlb_requestor.sv
rtl/nlb_lpbk.sv
tb/nlb_lpbk_properties.sv
tb/tb_nlb_lpbk.sv

/* Makefile */
TOP := tb_nlb_lpbk

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f list.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
